/* cpu_pkg.sv */
package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int XLEN      = 32;    // Data and instruction word
  localparam int RAM_DEPTH = 2048;  // Instruction memory entries
  localparam int RAM_AW    = 11;    // Word address into instruction memory
  localparam int NREG      = 32;    // Architectural registers
  localparam int REG_AW    = 5;     // Register index
  localparam int OPC_W     = 6;     // Opcode and funct fields
  localparam int SHAMT_W   = 5;     // Shift amount field
  localparam int IMM_W     = 16;    // I-type immediate

  // Primary opcodes
  localparam logic [OPC_W-1:0] OP_RTYPE = 6'h00;
  localparam logic [OPC_W-1:0] OP_BEQ   = 6'h04;
  localparam logic [OPC_W-1:0] OP_BNE   = 6'h05;
  localparam logic [OPC_W-1:0] OP_ADDI  = 6'h08;
  localparam logic [OPC_W-1:0] OP_ANDI  = 6'h0c;
  localparam logic [OPC_W-1:0] OP_ORI   = 6'h0d;
  localparam logic [OPC_W-1:0] OP_LUI   = 6'h0f;
  localparam logic [OPC_W-1:0] OP_HALT  = 6'h3f;

  // R-type function codes
  localparam logic [OPC_W-1:0] FN_SLL = 6'h00;  // All-zero word decodes as a NOP
  localparam logic [OPC_W-1:0] FN_ADD = 6'h20;
  localparam logic [OPC_W-1:0] FN_SUB = 6'h22;
  localparam logic [OPC_W-1:0] FN_AND = 6'h24;
  localparam logic [OPC_W-1:0] FN_OR  = 6'h25;
  localparam logic [OPC_W-1:0] FN_XOR = 6'h26;
  localparam logic [OPC_W-1:0] FN_SLT = 6'h2a;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_PASSB
  } alu_op_e;

  typedef enum logic [1:0] {
    FETCH, DECODE, EXEC, RESULT
  } state_e;

  // One instruction word with its two field layouts
  typedef union packed {
    struct packed {
      logic [OPC_W-1:0]   opcode;
      logic [REG_AW-1:0]  rs;
      logic [REG_AW-1:0]  rt;
      logic [REG_AW-1:0]  rd;     // Destination for R-type
      logic [SHAMT_W-1:0] shamt;
      logic [OPC_W-1:0]   funct;
    } r_fmt;
    struct packed {
      logic [OPC_W-1:0]   opcode;
      logic [REG_AW-1:0]  rs;
      logic [REG_AW-1:0]  rt;     // Destination for ALU immediates
      logic [IMM_W-1:0]   imm16;
    } i_fmt;
  } instr_u;

endpackage

/* instr_ram.sv */
module instr_ram import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_ena,    // Port enable, idle otherwise
  input  logic              i_wea,    // Write strobe
  input  logic [RAM_AW-1:0] i_addra,
  input  logic [XLEN-1:0]   i_dina,
  output logic [XLEN-1:0]   o_douta
);

  // Single-port no-change memory
  // A write leaves the read latch untouched, which keeps the output quiet

  logic [XLEN-1:0] mem [RAM_DEPTH] = '{default: '0};  // Comes up cleared
  logic [XLEN-1:0] ram_data = '0;                     // Read latch

  always_ff @(posedge i_clka) begin
    if (i_ena) begin
      if (i_wea) begin
        mem[i_addra] <= i_dina;     // Write only
      end else begin
        ram_data <= mem[i_addra];   // One cycle read latency
      end
    end
  end

  // Low-latency build, no extra output stage
  assign o_douta = ram_data;

endmodule

/* instr_fetch.sv */
module instr_fetch import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_rsta,
  input  logic              i_run,            // Level, starts the core
  input  logic              i_load_we,        // Program load strobe
  input  logic [RAM_AW-1:0] i_load_addr,
  input  logic              i_branch_taken,   // Valid in RESULT
  input  logic [RAM_AW-1:0] i_branch_target,
  input  logic              i_halt,           // Current instruction is HALT
  output state_e            o_state,
  output logic              o_ram_en,
  output logic              o_ram_we,
  output logic [RAM_AW-1:0] o_ram_addr
);

  logic              run_q;    // Sticky once i_run is seen
  logic [RAM_AW-1:0] pc_q;
  state_e            state_q;
  logic              load_ok;

  // Loads are accepted only before the core starts
  assign load_ok = i_load_we & ~i_run & ~run_q;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer and PC
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clka) begin
    if (i_rsta) begin
      run_q   <= 1'b0;
      state_q <= FETCH;
      pc_q    <= '0;
    end else begin
      if (i_run) run_q <= 1'b1;
      if (run_q) begin                 // Idle in FETCH until started
        case (state_q)
          FETCH:  state_q <= DECODE;
          DECODE: state_q <= EXEC;
          EXEC:   state_q <= RESULT;
          RESULT: begin
            if (!i_halt) begin         // HALT parks the sequencer here
              state_q <= FETCH;
              pc_q    <= i_branch_taken ? i_branch_target : pc_q + RAM_AW'(1);
            end
          end
          default: state_q <= FETCH;
        endcase
      end
    end
  end

  assign o_state    = state_q;
  // RAM port belongs to the load path until the core runs
  assign o_ram_en   = run_q ? (state_q == FETCH) : load_ok;
  assign o_ram_we   = load_ok;
  assign o_ram_addr = run_q ? pc_q : i_load_addr;  // PC also feeds branch target

endmodule

/* instr_decode.sv */
module instr_decode import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_rsta,
  input  state_e            i_state,
  input  instr_u            i_instr,     // RAM output, valid in DECODE
  output logic [REG_AW-1:0] o_rs_addr,
  output logic [REG_AW-1:0] o_rt_addr,
  input  logic [XLEN-1:0]   i_rs_data,
  input  logic [XLEN-1:0]   i_rt_data,
  output logic [XLEN-1:0]   o_op_a,
  output logic [XLEN-1:0]   o_op_b,
  output alu_op_e           o_alu_op,
  output logic [REG_AW-1:0] o_dest,
  output logic              o_writes,    // Instruction writes a register
  output logic              o_is_beq,
  output logic              o_is_bne,
  output logic              o_is_halt,
  output logic [XLEN-1:0]   o_imm        // Extended immediate
);

  logic [OPC_W-1:0]  opcode;
  logic [IMM_W-1:0]  imm16;
  logic [XLEN-1:0]   imm_sext;
  logic [XLEN-1:0]   imm_zext;
  logic [XLEN-1:0]   op_a_d;
  logic [XLEN-1:0]   op_b_d;
  logic [XLEN-1:0]   imm_d;
  alu_op_e           alu_op_d;
  logic [REG_AW-1:0] dest_d;
  logic              writes_d;
  logic              is_beq_d;
  logic              is_bne_d;
  logic              is_halt_d;

  assign opcode    = i_instr.r_fmt.opcode;     // Same place in both layouts
  assign imm16     = i_instr.i_fmt.imm16;
  assign imm_sext  = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
  assign imm_zext  = {{(XLEN-IMM_W){1'b0}}, imm16};
  assign o_rs_addr = i_instr.r_fmt.rs;         // Register reads in DECODE
  assign o_rt_addr = i_instr.r_fmt.rt;

  ////////////////////////////////////////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    op_a_d    = i_rs_data;
    op_b_d    = i_rt_data;
    imm_d     = imm_sext;                      // Branch offsets are signed
    alu_op_d  = ALU_ADD;
    dest_d    = i_instr.i_fmt.rt;
    writes_d  = 1'b0;
    is_beq_d  = 1'b0;
    is_bne_d  = 1'b0;
    is_halt_d = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        dest_d   = i_instr.r_fmt.rd;
        writes_d = 1'b1;
        case (i_instr.r_fmt.funct)
          FN_ADD: alu_op_d = ALU_ADD;
          FN_SUB: alu_op_d = ALU_SUB;
          FN_AND: alu_op_d = ALU_AND;
          FN_OR:  alu_op_d = ALU_OR;
          FN_XOR: alu_op_d = ALU_XOR;
          FN_SLT: alu_op_d = ALU_SLT;
          FN_SLL: begin
            alu_op_d = ALU_SLL;
            op_a_d   = i_rt_data;                     // rd = rt << shamt
            op_b_d   = XLEN'(i_instr.r_fmt.shamt);
          end
          default: writes_d = 1'b0;                   // Unknown funct is a NOP
        endcase
      end
      OP_ADDI: begin
        op_b_d   = imm_sext;
        writes_d = 1'b1;
      end
      OP_ANDI: begin
        op_b_d   = imm_zext;
        imm_d    = imm_zext;
        alu_op_d = ALU_AND;
        writes_d = 1'b1;
      end
      OP_ORI: begin
        op_b_d   = imm_zext;
        imm_d    = imm_zext;
        alu_op_d = ALU_OR;
        writes_d = 1'b1;
      end
      OP_LUI: begin
        op_b_d   = {imm16, {(XLEN-IMM_W){1'b0}}};   // Upper half, low half clear
        alu_op_d = ALU_PASSB;
        writes_d = 1'b1;
      end
      OP_BEQ:  is_beq_d  = 1'b1;                     // Compares rs with rt
      OP_BNE:  is_bne_d  = 1'b1;
      OP_HALT: is_halt_d = 1'b1;
      default: ;                                     // Unknown opcode is a NOP
    endcase
  end

  // Control flags, captured in DECODE
  always_ff @(posedge i_clka) begin
    if (i_rsta) begin
      o_alu_op  <= ALU_ADD;
      o_dest    <= '0;
      o_writes  <= 1'b0;
      o_is_beq  <= 1'b0;
      o_is_bne  <= 1'b0;
      o_is_halt <= 1'b0;
    end else if (i_state == DECODE) begin
      o_alu_op  <= alu_op_d;
      o_dest    <= dest_d;
      o_writes  <= writes_d;
      o_is_beq  <= is_beq_d;
      o_is_bne  <= is_bne_d;
      o_is_halt <= is_halt_d;
    end
  end

  // Operand payload
  always_ff @(posedge i_clka) begin
    if (i_state == DECODE) begin
      o_op_a <= op_a_d;
      o_op_b <= op_b_d;
      o_imm  <= imm_d;
    end
  end

endmodule

/* reg_file.sv */
module reg_file import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_rsta,
  input  logic [REG_AW-1:0] i_rs_addr,
  input  logic [REG_AW-1:0] i_rt_addr,
  output logic [XLEN-1:0]   o_rs_data,   // Asynchronous read
  output logic [XLEN-1:0]   o_rt_data,
  input  logic              i_we,
  input  logic [REG_AW-1:0] i_wr_addr,
  input  logic [XLEN-1:0]   i_wr_data
);

  logic [XLEN-1:0] regs [NREG];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clka) begin
    if (i_rsta) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;               // Whole file clears
      end
    end else begin
      // Entry 0 has no write decode so it stays at zero
      for (int i = 1; i < NREG; i++) begin
        if (i_we && i_wr_addr == REG_AW'(i)) begin
          regs[i] <= i_wr_data;
        end
      end
    end
  end

  // Read ports, combinational
  assign o_rs_data = regs[i_rs_addr];
  assign o_rt_data = regs[i_rt_addr];

endmodule

/* alu_execute.sv */
module alu_execute import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_rsta,
  input  state_e            i_state,
  input  logic [XLEN-1:0]   i_op_a,
  input  logic [XLEN-1:0]   i_op_b,
  input  alu_op_e           i_alu_op,
  input  logic              i_is_beq,
  input  logic              i_is_bne,
  input  logic [XLEN-1:0]   i_imm,          // Sign-extended branch offset
  input  logic [RAM_AW-1:0] i_pc,           // Address of the current instruction
  output logic [XLEN-1:0]   o_result,
  output logic              o_branch_taken,
  output logic [RAM_AW-1:0] o_branch_target
);

  logic [XLEN-1:0]   alu_d;
  logic              slt_d;
  logic              eq_d;
  logic              taken_d;
  logic [RAM_AW-1:0] target_d;

  assign slt_d = $signed(i_op_a) < $signed(i_op_b);   // Signed compare

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (i_alu_op)
      ALU_ADD:   alu_d = i_op_a + i_op_b;
      ALU_SUB:   alu_d = i_op_a - i_op_b;
      ALU_AND:   alu_d = i_op_a & i_op_b;
      ALU_OR:    alu_d = i_op_a | i_op_b;
      ALU_XOR:   alu_d = i_op_a ^ i_op_b;
      ALU_SLT:   alu_d = {{(XLEN-1){1'b0}}, slt_d};
      ALU_SLL:   alu_d = i_op_a << i_op_b[SHAMT_W-1:0];  // Shamt rides in op B
      ALU_PASSB: alu_d = i_op_b;                         // LUI
      default:   alu_d = '0;
    endcase
  end

  // Branch compare and target, PC + 1 + offset
  assign eq_d     = (i_op_a == i_op_b);
  assign taken_d  = (i_is_beq & eq_d) | (i_is_bne & ~eq_d);
  assign target_d = i_pc + RAM_AW'(1) + i_imm[RAM_AW-1:0];

  always_ff @(posedge i_clka) begin
    if (i_rsta) begin
      o_branch_taken <= 1'b0;
    end else if (i_state == EXEC) begin
      o_branch_taken <= taken_d;     // Held through RESULT
    end
  end

  always_ff @(posedge i_clka) begin
    if (i_state == EXEC) begin
      o_result        <= alu_d;
      o_branch_target <= target_d;
    end
  end

endmodule

/* result_writeback.sv */
module result_writeback import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_rsta,
  input  state_e            i_state,
  input  logic [XLEN-1:0]   i_result,
  input  logic [REG_AW-1:0] i_dest,
  input  logic              i_writes,
  input  logic              i_is_halt,
  output logic              o_rf_we,
  output logic [REG_AW-1:0] o_rf_addr,
  output logic [XLEN-1:0]   o_rf_data,
  output logic              o_wb_valid,   // One-cycle retirement pulse
  output logic [REG_AW-1:0] o_wb_reg,
  output logic [XLEN-1:0]   o_wb_data,
  output logic              o_halted
);

  logic commit;
  logic halted_q;

  // Writes to register 0 are dropped here and never reported
  assign commit = (i_state == RESULT) && i_writes && (i_dest != '0);

  assign o_rf_we    = commit;
  assign o_rf_addr  = i_dest;
  assign o_rf_data  = i_result;
  assign o_wb_valid = commit;       // Same cycle as the register write
  assign o_wb_reg   = i_dest;
  assign o_wb_data  = i_result;

  // Halt flag, cleared only by reset
  always_ff @(posedge i_clka) begin
    if (i_rsta) begin
      halted_q <= 1'b0;
    end else if (i_state == RESULT && i_is_halt) begin
      halted_q <= 1'b1;
    end
  end

  assign o_halted = halted_q;

endmodule

/* cpu_top.sv */
module cpu_top import cpu_pkg::*; (
  input  logic              i_clka,
  input  logic              i_rsta,
  input  logic              i_run,
  input  logic              i_load_we,
  input  logic [RAM_AW-1:0] i_load_addr,
  input  logic [XLEN-1:0]   i_load_data,
  output logic              o_wb_valid,
  output logic [REG_AW-1:0] o_wb_reg,
  output logic [XLEN-1:0]   o_wb_data,
  output logic              o_halted
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////
  state_e            state;
  logic              ram_en, ram_we;
  logic [RAM_AW-1:0] ram_addr;         // Load address or PC
  logic [XLEN-1:0]   ram_dout;
  logic [REG_AW-1:0] rs_addr, rt_addr;
  logic [XLEN-1:0]   rs_data, rt_data;
  logic [XLEN-1:0]   op_a, op_b, imm;
  alu_op_e           alu_op;
  logic [REG_AW-1:0] dest;
  logic              writes, is_beq, is_bne, is_halt;
  logic [XLEN-1:0]   result;
  logic              branch_taken;
  logic [RAM_AW-1:0] branch_target;
  logic              rf_we;
  logic [REG_AW-1:0] rf_addr;
  logic [XLEN-1:0]   rf_data;

  instr_fetch u_fetch (
    .i_clka, .i_rsta, .i_run, .i_load_we, .i_load_addr,
    .i_branch_taken(branch_taken), .i_branch_target(branch_target), .i_halt(is_halt),
    .o_state(state), .o_ram_en(ram_en), .o_ram_we(ram_we), .o_ram_addr(ram_addr)
  );

  instr_ram u_ram (
    .i_clka, .i_ena(ram_en), .i_wea(ram_we), .i_addra(ram_addr),
    .i_dina(i_load_data), .o_douta(ram_dout)
  );

  instr_decode u_decode (
    .i_clka, .i_rsta, .i_state(state), .i_instr(ram_dout),
    .o_rs_addr(rs_addr), .o_rt_addr(rt_addr), .i_rs_data(rs_data), .i_rt_data(rt_data),
    .o_op_a(op_a), .o_op_b(op_b), .o_alu_op(alu_op), .o_dest(dest), .o_writes(writes),
    .o_is_beq(is_beq), .o_is_bne(is_bne), .o_is_halt(is_halt), .o_imm(imm)
  );

  reg_file u_regs (
    .i_clka, .i_rsta, .i_rs_addr(rs_addr), .i_rt_addr(rt_addr),
    .o_rs_data(rs_data), .o_rt_data(rt_data),
    .i_we(rf_we), .i_wr_addr(rf_addr), .i_wr_data(rf_data)
  );

  alu_execute u_alu (
    .i_clka, .i_rsta, .i_state(state), .i_op_a(op_a), .i_op_b(op_b), .i_alu_op(alu_op),
    .i_is_beq(is_beq), .i_is_bne(is_bne), .i_imm(imm), .i_pc(ram_addr),
    .o_result(result), .o_branch_taken(branch_taken), .o_branch_target(branch_target)
  );

  result_writeback u_wb (
    .i_clka, .i_rsta, .i_state(state), .i_result(result), .i_dest(dest),
    .i_writes(writes), .i_is_halt(is_halt),
    .o_rf_we(rf_we), .o_rf_addr(rf_addr), .o_rf_data(rf_data),
    .o_wb_valid, .o_wb_reg, .o_wb_data, .o_halted
  );

endmodule

/* tb_cpu_properties.sv */
module tb_cpu_properties (
  input logic i_clka,
  input logic i_rsta,
  input logic i_wb_valid,   // Retirement pulse of the core
  input logic i_halted
);

  timeunit 1ns;
  timeprecision 1ps;

  // Core comes out of reset quiet
  reset_quiet: assert property (@(posedge i_clka) i_rsta |=> (!i_wb_valid && !i_halted))
    else $error("Write-back or halt active right after reset");

  // Single-cycle retirement pulse
  wb_single: assert property (@(posedge i_clka) disable iff (i_rsta)
    i_wb_valid |=> !i_wb_valid)
    else $error("Write-back pulse lasted two cycles");

  // At least a full four-cycle instruction between retirements
  wb_spacing: assert property (@(posedge i_clka) disable iff (i_rsta)
    i_wb_valid |=> !i_wb_valid [*3])
    else $error("Retirements closer than four cycles");

  // Halt is sticky until reset
  halt_sticky: assert property (@(posedge i_clka) disable iff (i_rsta)
    i_halted |=> i_halted)
    else $error("Halt flag dropped without reset");

endmodule

bind cpu_top tb_cpu_properties u_props (
  .i_clka(i_clka), .i_rsta(i_rsta), .i_wb_valid(o_wb_valid), .i_halted(o_halted)
);

/* tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic              i_clka;
  logic              i_rsta;
  logic              i_run;
  logic              i_load_we;
  logic [RAM_AW-1:0] i_load_addr;
  logic [XLEN-1:0]   i_load_data;
  logic              o_wb_valid;
  logic [REG_AW-1:0] o_wb_reg;
  logic [XLEN-1:0]   o_wb_data;
  logic              o_halted;

  // Program table with one entry per RAM word
  logic [XLEN-1:0]   instr_q[$];   // Instruction word
  bit                wb_q[$];      // Expects a write-back
  logic [REG_AW-1:0] reg_q[$];     // Expected destination
  logic [XLEN-1:0]   val_q[$];     // Expected value
  int                step_q[$];    // Execution order or -1 if never executed

  int cyc;                         // Clock cycle count
  int start_cyc;                   // Cycle in which i_run goes high
  int halt_step;
  int errors;
  int timeouts;
  int wait_limit = 40;             // Cycles per wait before giving up
  int row;
  bit ok;

  cpu_top dut (
    .i_clka, .i_rsta, .i_run, .i_load_we, .i_load_addr, .i_load_data,
    .o_wb_valid, .o_wb_reg, .o_wb_data, .o_halted
  );

  initial i_clka = 1'b0;
  always #50 i_clka = ~i_clka;     // 100 ns period

  always @(posedge i_clka) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction assembly
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [XLEN-1:0] rtype_word(input logic [5:0] funct,
      input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
      input logic [4:0] shamt);
    return {OP_RTYPE, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [XLEN-1:0] itype_word(input logic [5:0] op,
      input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [XLEN-1:0] sign_extend(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic add_row(input logic [XLEN-1:0] word, input bit wb,
      input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] val, input int step);
    instr_q.push_back(word);
    wb_q.push_back(wb);
    reg_q.push_back(rd);
    val_q.push_back(val);
    step_q.push_back(step);
  endtask

  // Program with its predicted results from the ISA rules
  task automatic build_program();
    logic [15:0]     imm_a, imm_b, imm_c, imm_d, imm_e;
    logic [XLEN-1:0] r1, r2, r3, r4, r5, r11;
    imm_a = {1'b1, 15'($urandom())};             // Negative after sign extension
    imm_b = {1'b0, 15'($urandom())};             // Positive
    imm_c = {1'b1, 15'($urandom())};             // Top bit set so extension matters
    imm_d = {1'b1, 15'($urandom())};
    imm_e = 16'($urandom());
    r1  = sign_extend(imm_a);
    r2  = sign_extend(imm_b);
    r3  = r1 & {16'h0, imm_c};                   // ANDI zero-extends
    r4  = r2 | {16'h0, imm_d};                   // ORI zero-extends
    r5  = {imm_e, 16'h0};                        // LUI
    r11 = sign_extend(16'hfff0);
    add_row(itype_word(OP_ADDI, 0, 1, imm_a), 1, 1, r1, 0);
    add_row(itype_word(OP_ADDI, 0, 2, imm_b), 1, 2, r2, 1);
    add_row(itype_word(OP_ANDI, 1, 3, imm_c), 1, 3, r3, 2);
    add_row(itype_word(OP_ORI, 2, 4, imm_d), 1, 4, r4, 3);
    add_row(itype_word(OP_LUI, 0, 5, imm_e), 1, 5, r5, 4);
    add_row(rtype_word(FN_ADD, 1, 2, 6, 0), 1, 6, r1 + r2, 5);
    add_row(rtype_word(FN_SUB, 1, 2, 7, 0), 1, 7, r1 - r2, 6);
    add_row(rtype_word(FN_AND, 3, 4, 8, 0), 1, 8, r3 & r4, 7);
    add_row(rtype_word(FN_OR, 3, 4, 9, 0), 1, 9, r3 | r4, 8);
    add_row(rtype_word(FN_XOR, 1, 5, 10, 0), 1, 10, r1 ^ r5, 9);
    add_row(itype_word(OP_ADDI, 0, 11, 16'hfff0), 1, 11, r11, 10);
    add_row(rtype_word(FN_SLT, 11, 2, 12, 0), 1, 12,
            ($signed(r11) < $signed(r2)) ? 32'd1 : 32'd0, 11);    // Negative against positive
    add_row(rtype_word(FN_SLL, 0, 1, 13, 4), 1, 13, r1 << 4, 12);
    add_row(itype_word(OP_ADDI, 0, 0, 16'h1234), 0, 0, 0, 13);    // Dropped write to x0
    add_row(rtype_word(FN_ADD, 0, 0, 14, 0), 1, 14, 0, 14);       // x0 still reads zero
    add_row(itype_word(OP_BEQ, 0, 0, 16'd2), 0, 0, 0, 15);        // Taken to row 18
    add_row(itype_word(OP_ADDI, 0, 15, 16'd1), 0, 0, 0, -1);      // Skipped
    add_row(itype_word(OP_ADDI, 0, 16, 16'd2), 0, 0, 0, -1);      // Skipped
    add_row(itype_word(OP_BNE, 1, 1, 16'd3), 0, 0, 0, 16);        // Not taken
    add_row(itype_word(OP_ADDI, 0, 17, 16'h0055), 1, 17, 32'h55, 17);
    add_row(itype_word(OP_HALT, 0, 0, 16'h0), 0, 0, 0, 18);
    add_row(itype_word(OP_ADDI, 0, 18, 16'd7), 0, 0, 0, -1);      // Past the HALT
    halt_step = 18;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Load, wait and check helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic load_program();
    for (int a = 0; a < instr_q.size(); a++) begin
      @(posedge i_clka);
      i_load_we   <= 1'b1;
      i_load_addr <= RAM_AW'(a);
      i_load_data <= instr_q[a];
    end
    @(posedge i_clka);
    i_load_we <= 1'b0;
  endtask

  task automatic wait_retire(output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < wait_limit) begin
      @(negedge i_clka);                         // Outputs settled mid-cycle
      seen = o_wb_valid;
      n++;
    end
  endtask

  task automatic wait_halt(output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < wait_limit) begin
      @(negedge i_clka);
      if (o_wb_valid) begin
        $display("Error at %0t: unexpected write-back to x%0d", $time, o_wb_reg);
        errors++;
      end
      seen = o_halted;
      n++;
    end
  endtask

  task automatic check_retire(input int r);
    int exp_cyc;
    exp_cyc = start_cyc + 4 * (step_q[r] + 1);   // Four cycles per instruction
    if (o_wb_reg !== reg_q[r]) begin
      $display("Error at %0t: row %0d wrote x%0d, expected x%0d",
               $time, r, o_wb_reg, reg_q[r]);
      errors++;
    end
    if (o_wb_data !== val_q[r]) begin
      $display("Error at %0t: row %0d data %h, expected %h", $time, r, o_wb_data, val_q[r]);
      errors++;
    end
    if (cyc != exp_cyc) begin
      $display("Error at %0t: row %0d retired in cycle %0d, expected %0d",
               $time, r, cyc, exp_cyc);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    i_rsta      = 1'b1;
    i_run       = 1'b0;
    i_load_we   = 1'b0;
    i_load_addr = '0;
    i_load_data = '0;
    errors      = 0;
    timeouts    = 0;
    void'($urandom(32'hfacb));
    build_program();
    repeat (2) @(posedge i_clka);
    i_rsta <= 1'b0;
    load_program();
    @(posedge i_clka);
    i_run <= 1'b1;
    @(negedge i_clka);
    start_cyc = cyc;                             // First FETCH is the next cycle
    for (row = 0; row < instr_q.size() && timeouts == 0; row++) begin
      if (wb_q[row]) begin
        wait_retire(ok);
        if (!ok) begin
          $display("Timeout: no write-back arrived for program row %0d", row);
          timeouts++;
        end else begin
          check_retire(row);
        end
      end
    end
    if (timeouts == 0) begin
      wait_halt(ok);
      if (!ok) begin
        $display("Timeout: the core never raised o_halted");
        timeouts++;
      end else if (cyc != start_cyc + 4 * (halt_step + 1) + 1) begin
        $display("Error at %0t: o_halted rose in cycle %0d", $time, cyc);
        errors++;
      end
    end
    repeat (12) begin                            // Nothing retires after HALT
      @(negedge i_clka);
      if (o_wb_valid) begin
        $display("Error at %0t: write-back to x%0d after halt", $time, o_wb_reg);
        errors++;
      end
    end
    $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* files.f */
cpu_pkg.sv
instr_ram.sv
instr_fetch.sv
instr_decode.sv
reg_file.sv
alu_execute.sv
result_writeback.sv
cpu_top.sv
tb_cpu_properties.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - instr_ram.sv
  - instr_fetch.sv
  - instr_decode.sv
  - reg_file.sv
  - alu_execute.sv
  - result_writeback.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu_properties.sv
      - tb_cpu.sv
